// File: verilog/vec_cfg_pkg.sv
`default_nettype none

package vec_cfg_pkg;

    localparam int chunk_w      = 64;   // bits in one mask chunk.
    localparam int chunk_idx_w  = 4;    // up to 16 chunks, 1024 mask bits.
    localparam int bit_idx_w    = 6;    // position within a chunk.
    localparam int result_w     = 64;
    localparam int tag_w        = 5;    // destination tag.

    localparam int req_depth    = 4;    // also upstream credits after reset.
    localparam int resp_depth   = 4;

    localparam int unit_latency = 3;    // last-beat pop to result push.

    // free-slot count of the response FIFO, 0 to resp_depth.
    localparam int resp_cnt_w   = $clog2(resp_depth + 1);

    localparam int credit_cnt_w = 8;    // response credits held by the top.

endpackage

`default_nettype wire

// File: verilog/mask_op_pkg.sv
`default_nettype none

package mask_op_pkg;

    import vec_cfg_pkg::*;

    typedef enum logic {
        op_first = 1'b0,    // find first set mask bit.
        op_popc  = 1'b1     // mask population count.
    } mask_op_e;

    // one mask chunk of a request, 75 bits.
    typedef struct packed {
        logic [chunk_w-1:0]     mask;
        logic [chunk_idx_w-1:0] chunk_idx;
        logic                   last;       // final chunk of the request.
        mask_op_e               op;
        logic [tag_w-1:0]       tag;
    } mask_req_t;

    // one finished request, 69 bits.
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [result_w-1:0] result;
    } mask_resp_t;

endpackage

`default_nettype wire

// File: verilog/credit_fifo.sv
`default_nettype none

module credit_fifo #(
    parameter int  depth     = 4,
    parameter type payload_t = logic
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          push,
    input  wire payload_t                      push_data,
    input  wire logic                          pop,
    output payload_t                           head,
    output logic                               head_valid,
    output logic     [$clog2(depth + 1)-1:0]   free,
    output logic                               credit
);

    localparam int cnt_w = $clog2(depth + 1);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // idle, or push and pop together.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);
    assign free       = cnt_w'(depth) - count;
    assign credit     = pop;             // one slot handed back per pop.

endmodule

`default_nettype wire

// File: verilog/first_bit_finder.sv
`default_nettype none

module first_bit_finder
    import vec_cfg_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   valid,
    input  wire logic [chunk_w-1:0]     chunk,
    input  wire logic [chunk_idx_w-1:0] chunk_idx,
    output logic      [result_w-1:0]    index,
    output logic                        found
);

    logic [bit_idx_w-1:0] pos;
    logic                 any_set;

    // scan from the top so the lowest set bit wins.
    always_comb begin
        pos = '0;
        for (int i = chunk_w - 1; i >= 0; i--) begin
            if (chunk[i]) begin
                pos = bit_idx_w'(i);
            end
        end
    end

    assign any_set = |chunk;

    always_ff @(posedge clk) begin
        if (rst) begin
            found <= 1'b0;
        end else begin
            found <= valid && any_set;
        end
    end

    // chunk_idx * 64 + pos is a plain concatenation.
    always_ff @(posedge clk) begin
        index <= result_w'({chunk_idx, pos});
    end

endmodule

`default_nettype wire

// File: verilog/popcount_acc.sv
`default_nettype none

module popcount_acc
    import vec_cfg_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                valid,
    input  wire logic [chunk_w-1:0]  chunk,
    input  wire logic                restart,
    output logic      [result_w-1:0] sum
);

    logic [bit_idx_w:0] ones;    // 0 to 64.

    always_comb begin
        ones = '0;
        for (int i = 0; i < chunk_w; i++) begin
            ones = ones + (bit_idx_w + 1)'(chunk[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else if (valid) begin
            if (restart) begin
                sum <= result_w'(ones);           // first beat of a request.
            end else begin
                sum <= sum + result_w'(ones);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mask_reduce_unit.sv
`default_nettype none

module mask_reduce_unit
    import vec_cfg_pkg::*;
    import mask_op_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mask_req_t             head,
    input  wire logic                  head_valid,
    input  wire logic [resp_cnt_w-1:0] resp_free,
    output logic                       pop,
    output mask_resp_t                 result,
    output logic                       result_valid
);

    logic [resp_cnt_w-1:0] pending;     // last beat popped, result not yet pushed.
    logic [resp_cnt_w-1:0] need;
    logic                  prev_last;

    mask_req_t             s0_req;
    logic                  s0_valid;
    logic                  s0_first;

    logic                  s1_last;
    mask_op_e              s1_op;
    logic [tag_w-1:0]      s1_tag;

    logic [result_w-1:0]   fb_index;
    logic                  fb_found;
    logic [result_w-1:0]   pc_sum;

    logic [result_w-1:0]   first_idx;
    logic                  first_found;
    logic [result_w-1:0]   result_sel;

    // admit only while every unfinished request has a response slot.
    assign need = pending + resp_cnt_w'(head.last);
    assign pop  = head_valid && (need < resp_free);

    first_bit_finder u_first_bit_finder (
        .clk       (clk),
        .rst       (rst),
        .valid     (s0_valid),
        .chunk     (s0_req.mask),
        .chunk_idx (s0_req.chunk_idx),
        .index     (fb_index),
        .found     (fb_found)
    );

    popcount_acc u_popcount_acc (
        .clk     (clk),
        .rst     (rst),
        .valid   (s0_valid),
        .chunk   (s0_req.mask),
        .restart (s0_first),
        .sum     (pc_sum)
    );

    always_comb begin
        if (s1_op == op_popc) begin
            result_sel = pc_sum;
        end else if (first_found) begin
            result_sel = first_idx;           // an earlier chunk already hit.
        end else if (fb_found) begin
            result_sel = fb_index;
        end else begin
            result_sel = '1;                  // no bit set anywhere.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending      <= '0;
            prev_last    <= 1'b1;
            s0_valid     <= 1'b0;
            s1_last      <= 1'b0;
            first_found  <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            pending <= pending + resp_cnt_w'(pop && head.last)
                     - resp_cnt_w'(result_valid);
            if (pop) begin
                prev_last <= head.last;
            end
            s0_valid <= pop;
            s1_last  <= s0_valid && s0_req.last;
            if (s1_last) begin
                first_found <= 1'b0;          // next request starts clean.
            end else if (fb_found) begin
                first_found <= 1'b1;
            end
            result_valid <= s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            s0_req   <= head;
            s0_first <= prev_last;
        end
        s1_op  <= s0_req.op;                  // lines up with the child outputs.
        s1_tag <= s0_req.tag;
        if (fb_found && !first_found) begin
            first_idx <= fb_index;
        end
        result.tag    <= s1_tag;
        result.result <= result_sel;
    end

endmodule

`default_nettype wire

// File: verilog/mask_reduce_top.sv
`default_nettype none

module mask_reduce_top
    import vec_cfg_pkg::*;
    import mask_op_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire mask_req_t  req,
    input  wire logic       req_valid,
    output logic            req_credit,
    output mask_resp_t      resp,
    output logic            resp_valid,
    input  wire logic       resp_credit
);

    mask_req_t               req_head;
    logic                    req_head_valid;
    logic                    unit_pop;

    mask_resp_t              unit_result;
    logic                    unit_result_valid;
    logic [resp_cnt_w-1:0]   resp_free;
    logic                    resp_head_valid;

    logic [credit_cnt_w-1:0] resp_credits;

    credit_fifo #(
        .depth     (req_depth),
        .payload_t (mask_req_t)
    ) u_req_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (req_valid),
        .push_data  (req),
        .pop        (unit_pop),
        .head       (req_head),
        .head_valid (req_head_valid),
        .free       (),
        .credit     (req_credit)
    );

    mask_reduce_unit u_unit (
        .clk          (clk),
        .rst          (rst),
        .head         (req_head),
        .head_valid   (req_head_valid),
        .resp_free    (resp_free),
        .pop          (unit_pop),
        .result       (unit_result),
        .result_valid (unit_result_valid)
    );

    credit_fifo #(
        .depth     (resp_depth),
        .payload_t (mask_resp_t)
    ) u_resp_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (unit_result_valid),
        .push_data  (unit_result),
        .pop        (resp_valid),
        .head       (resp),
        .head_valid (resp_head_valid),
        .free       (resp_free),
        .credit     ()
    );

    // send whenever a result waits and downstream has granted room.
    assign resp_valid = resp_head_valid && (resp_credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_credits <= '0;
        end else begin
            resp_credits <= resp_credits + credit_cnt_w'(resp_credit)
                          - credit_cnt_w'(resp_valid);
        end
    end

endmodule

`default_nettype wire

// File: dv/mask_reduce_checker.sv
`default_nettype none

module mask_reduce_checker
    import vec_cfg_pkg::*;
(
    input wire logic clk,
    input wire logic rst,
    input wire logic req_valid,
    input wire logic req_credit,
    input wire logic resp_valid,
    input wire logic resp_credit,
    input wire logic unit_pop,
    input wire logic head_last,
    input wire logic result_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0]  up_credits;     // credits upstream holds.
    logic [15:0] resp_grants;    // resp_credit pulses from downstream.
    logic [15:0] resp_sends;     // results sent to downstream.
    logic        last_pop;

    assign last_pop = unit_pop && head_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            up_credits  <= 4'(req_depth);
            resp_grants <= '0;
            resp_sends  <= '0;
        end else begin
            up_credits  <= up_credits - 4'(req_valid) + 4'(req_credit);
            resp_grants <= resp_grants + 16'(resp_credit);
            resp_sends  <= resp_sends + 16'(resp_valid);
        end
    end

    a_req_credit: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> up_credits != '0)
        else $error("request beat sent without a credit");

    a_resp_credit: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> resp_grants > resp_sends)
        else $error("response sent without a credit");

    a_result_after_pop: assert property (@(posedge clk) disable iff (rst)
        last_pop |-> ##unit_latency result_valid)
        else $error("no result 3 cycles after a last-beat pop");

    a_result_has_pop: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> $past(last_pop, unit_latency))
        else $error("result without a last-beat pop 3 cycles earlier");

endmodule

bind mask_reduce_top mask_reduce_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .req_valid    (req_valid),
    .req_credit   (req_credit),
    .resp_valid   (resp_valid),
    .resp_credit  (resp_credit),
    .unit_pop     (unit_pop),
    .head_last    (req_head.last),
    .result_valid (unit_result_valid)
);

`default_nettype wire

// File: dv/mask_reduce_tb.sv
`default_nettype none

module mask_reduce_tb
    import vec_cfg_pkg::*;
    import mask_op_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int total_beats = 96;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    mask_req_t  req = '0;
    logic       req_valid = 1'b0;
    logic       req_credit;
    mask_resp_t resp;
    logic       resp_valid;
    logic       resp_credit = 1'b0;

    int         sent = 0;
    int         returned = 0;      // req_credit pulses seen.
    int         granted = 0;       // resp_credit pulses given.
    int         received = 0;
    int         errors = 0;
    int         test_errors = 0;
    logic       grant_on = 1'b1;
    logic [4:0] next_tag = '0;
    string      cur_test = "reset";
    time        last_send_time;
    time        last_resp_time;

    logic [chunk_w-1:0] chunk_buf [16];
    mask_resp_t         exp_q [$];

    mask_reduce_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_valid   (req_valid),
        .req_credit  (req_credit),
        .resp        (resp),
        .resp_valid  (resp_valid),
        .resp_credit (resp_credit)
    );

    always #5 clk = ~clk;

    // downstream grants credits while enabled, holding at most two ahead.
    always @(posedge clk) begin
        if (rst) begin
            resp_credit <= 1'b0;
        end else begin
            resp_credit <= grant_on && (granted - received < 2);
        end
    end

    // sample at the falling edge, where all outputs are settled.
    always @(negedge clk) begin
        mask_resp_t e;
        if (!rst) begin
            if (req_credit) returned++;
            if (resp_credit) granted++;
            if (resp_valid) begin
                received++;
                last_resp_time = $time - 5;
                if (exp_q.size() == 0) begin
                    $display("%s: response with tag %0d arrived but none was expected",
                             cur_test, resp.tag);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    if (resp !== e) begin
                        $display("CHECK FAILED %s: expected tag %0d result %h, got tag %0d result %h",
                                 cur_test, e.tag, e.result, resp.tag, resp.result);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        repeat (total_beats * 20 + 1000) @(posedge clk);
        $display("timeout: the run did not finish in time");
        $display("Test failed");
        $finish;
    end

    function automatic logic [result_w-1:0] expected_first(input int n);
        for (int c = 0; c < n; c++) begin
            for (int b = 0; b < chunk_w; b++) begin
                if (chunk_buf[c][b]) return result_w'(c * chunk_w + b);
            end
        end
        return '1;
    endfunction

    function automatic logic [result_w-1:0] expected_popc(input int n);
        logic [result_w-1:0] total;
        total = '0;
        for (int c = 0; c < n; c++) begin
            for (int b = 0; b < chunk_w; b++) begin
                total = total + result_w'(chunk_buf[c][b]);
            end
        end
        return total;
    endfunction

    function automatic logic [chunk_w-1:0] random_chunk();
        return {$urandom, $urandom};
    endfunction

    task automatic send_beat(input mask_req_t b);
        @(posedge clk);
        while (req_depth - sent + returned <= 0) begin
            req_valid <= 1'b0;   // wait for a credit.
            @(posedge clk);
        end
        req            <= b;
        req_valid      <= 1'b1;
        sent++;
        last_send_time = $time;
    endtask

    task automatic idle();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // sends chunk_buf[0..n-1] as one request and queues its expected result.
    task automatic run_request(input mask_op_e op, input int n);
        mask_req_t  b;
        mask_resp_t e;
        e.tag    = next_tag;
        e.result = (op == op_first) ? expected_first(n) : expected_popc(n);
        exp_q.push_back(e);
        for (int c = 0; c < n; c++) begin
            b.mask      = chunk_buf[c];
            b.chunk_idx = chunk_idx_w'(c);
            b.last      = (c == n - 1);
            b.op        = op;
            b.tag       = next_tag;
            send_beat(b);
        end
        next_tag++;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("%s: finished with %0d errors", cur_test, errors - test_errors);
    endtask

    task automatic test_single_first();
        logic [chunk_w-1:0] masks [4];
        masks[0] = '0;
        masks[1] = 64'h1;
        masks[2] = 64'h8000_0000_0000_0000;
        masks[3] = random_chunk();
        start_test("single_first");
        for (int i = 0; i < 4; i++) begin
            drain();
            while (granted - received == 0) @(posedge clk);
            chunk_buf[0] = masks[i];
            run_request(op_first, 1);
            idle();
            drain();
            if (last_resp_time - last_send_time != 50) begin
                $display("CHECK FAILED %s: expected latency 5 cycles, got %0d cycles",
                         cur_test, (last_resp_time - last_send_time) / 10);
                errors++;
            end
        end
        end_test();
    endtask

    task automatic test_multi_first();
        int lens [3] = '{4, 9, 16};
        int k;
        start_test("multi_first");
        foreach (lens[i]) begin
            k = lens[i] / 2 + 1;                  // first hit in a later chunk.
            for (int c = 0; c < lens[i]; c++) begin
                chunk_buf[c] = (c < k) ? '0 : random_chunk();
            end
            chunk_buf[k] = chunk_buf[k] | (64'h1 << ($urandom % 64));
            run_request(op_first, lens[i]);
        end
        idle();
        drain();
        end_test();
    endtask

    task automatic test_popc();
        int lens [5] = '{1, 1, 1, 5, 16};
        start_test("popc");
        foreach (lens[i]) begin
            for (int c = 0; c < lens[i]; c++) chunk_buf[c] = random_chunk();
            if (i == 1) chunk_buf[0] = '1;
            run_request(op_popc, lens[i]);
        end
        idle();
        drain();
        end_test();
    endtask

    task automatic test_back_to_back();
        int n;
        start_test("back_to_back");
        for (int i = 0; i < 8; i++) begin
            n = (i % 3) + 1;
            for (int c = 0; c < n; c++) begin
                chunk_buf[c] = (i == 2) ? '0 : random_chunk();
            end
            run_request((i % 2 == 0) ? op_first : op_popc, n);
        end
        idle();
        drain();
        end_test();
    endtask

    task automatic test_back_pressure();
        int   r0;
        logic done_sending;
        done_sending = 1'b0;
        start_test("back_pressure");
        grant_on <= 1'b0;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    chunk_buf[0] = random_chunk();
                    chunk_buf[1] = (i % 4 == 0) ? '0 : random_chunk();
                    run_request((i % 2 == 0) ? op_popc : op_first, 2);
                end
                idle();
                done_sending = 1'b1;
            end
            begin
                repeat (150) @(posedge clk);
                r0 = returned;
                repeat (40) @(posedge clk);
                if (returned != r0) begin
                    $display("%s: request credits kept returning while responses were blocked",
                             cur_test);
                    errors++;
                end
                if (done_sending) begin
                    $display("%s: all requests were accepted with responses blocked",
                             cur_test);
                    errors++;
                end
                grant_on <= 1'b1;
            end
        join
        drain();
        end_test();
    endtask

    initial begin
        void'($urandom(32'h8783e075));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_single_first();
        test_multi_first();
        test_popc();
        test_back_to_back();
        test_back_pressure();
        $display("tests: 5, results: %0d, errors: %0d", received, errors);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/vec_cfg_pkg.sv
verilog/mask_op_pkg.sv
verilog/credit_fifo.sv
verilog/first_bit_finder.sv
verilog/popcount_acc.sv
verilog/mask_reduce_unit.sv
verilog/mask_reduce_top.sv
dv/mask_reduce_checker.sv
dv/mask_reduce_tb.sv

// File: Makefile
.PHONY: lint sim clean

TOP := mask_reduce_tb

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module mask_reduce_top
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
